// File: design/gat_dbg_pkg.sv
`default_nettype none

package gat_dbg_pkg;

  // sequencer state, also exported as the layer phase
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    SPMM = 3'd1,
    DMVM = 3'd2,
    SM   = 3'd3,
    AGGR = 3'd4,
    DONE = 3'd5
  } phase_e;

  // processing element output width
  localparam int SPPE_W = 12;

  // default number of processing elements
  localparam int NUM_PE = 16;

  // weight memory address width
  localparam int WH_ADDR_W = 14;

  // phase cycle counter width
  localparam int CNT_W = 16;

  // one sticky flag per engine strobe
  localparam int FLAG_W = 8;

  // default module parameter values
  localparam int DEF_PHASE_LIMIT  = 200;
  localparam int DEF_PROBE_PE     = 2;
  localparam int DEF_PROBE_ADDR_A = 10;
  localparam int DEF_PROBE_ADDR_B = 20;

endpackage

`default_nettype wire

// File: design/phase_if.sv
`timescale 1ns/1ps
`default_nettype none

interface phase_if;
  import gat_dbg_pkg::*;

  // engine start pulses
  logic spmm_vld;
  logic dmvm_vld;
  logic sm_vld;
  logic aggr_vld;

  // engine completion pulses
  logic spmm_rdy;
  logic dmvm_rdy;
  logic sm_rdy;
  logic aggr_rdy;

  phase_e phase;

  modport seq_mp (
    output spmm_vld, dmvm_vld, sm_vld, aggr_vld, phase,
    input  spmm_rdy, dmvm_rdy, sm_rdy, aggr_rdy
  );

  modport tmr_mp (
    input phase, spmm_rdy, dmvm_rdy, sm_rdy, aggr_rdy
  );

  modport prb_mp (
    input spmm_vld, dmvm_vld, sm_vld, aggr_vld, phase,
    input spmm_rdy, dmvm_rdy, sm_rdy, aggr_rdy
  );

endinterface

`default_nettype wire

// File: design/layer_seq.sv
`timescale 1ns/1ps
`default_nettype none

module layer_seq (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  logic      timeout_i,
  output logic      phase_start_o,
  output logic      busy_o,
  output logic      done_o,
  output logic      error_o,
  phase_if.seq_mp   pif
);
  import gat_dbg_pkg::*;

  phase_e state_q;
  phase_e state_d;
  logic   entry_q;
  logic   entry_d;
  logic   error_q;
  logic   error_d;

  always_comb begin
    state_d = state_q;
    entry_d = 1'b0;
    error_d = error_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = SPMM;
          entry_d = 1'b1;
          error_d = 1'b0;
        end
      end
      SPMM, DMVM, SM, AGGR: begin
        if (timeout_i) begin
          // hung engine abandons the layer
          state_d = IDLE;
          error_d = 1'b1;
        end else if (state_q == SPMM && pif.spmm_rdy) begin
          state_d = DMVM;
          entry_d = 1'b1;
        end else if (state_q == DMVM && pif.dmvm_rdy) begin
          state_d = SM;
          entry_d = 1'b1;
        end else if (state_q == SM && pif.sm_rdy) begin
          state_d = AGGR;
          entry_d = 1'b1;
        end else if (state_q == AGGR && pif.aggr_rdy) begin
          state_d = DONE;
        end
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      entry_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      state_q <= state_d;
      entry_q <= entry_d;
      error_q <= error_d;
    end
  end

  // valid is high only on the first cycle of each engine phase
  assign pif.spmm_vld = entry_q && (state_q == SPMM);
  assign pif.dmvm_vld = entry_q && (state_q == DMVM);
  assign pif.sm_vld   = entry_q && (state_q == SM);
  assign pif.aggr_vld = entry_q && (state_q == AGGR);
  assign pif.phase    = state_q;

  assign phase_start_o = entry_q;
  assign busy_o        = (state_q != IDLE) && (state_q != DONE);
  assign done_o        = (state_q == DONE);
  assign error_o       = error_q;

  a_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({pif.spmm_vld, pif.dmvm_vld, pif.sm_vld, pif.aggr_vld}))
    else $error("more than one engine valid");

endmodule

`default_nettype wire

// File: design/phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_timer #(
  parameter int PHASE_LIMIT = gat_dbg_pkg::DEF_PHASE_LIMIT
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          phase_start_i,
  phase_if.tmr_mp                       pif,
  output logic                          timeout_o,
  output logic [gat_dbg_pkg::CNT_W-1:0] longest_o
);
  import gat_dbg_pkg::*;

  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(PHASE_LIMIT);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cur_cnt;
  logic [CNT_W-1:0] longest_q;
  logic [CNT_W-1:0] base_longest;
  logic             running;
  logic             rdy_match;

  always_comb begin
    unique case (pif.phase)
      SPMM:    rdy_match = pif.spmm_rdy;
      DMVM:    rdy_match = pif.dmvm_rdy;
      SM:      rdy_match = pif.sm_rdy;
      AGGR:    rdy_match = pif.aggr_rdy;
      default: rdy_match = 1'b0;
    endcase
  end

  assign running = (pif.phase == SPMM) || (pif.phase == DMVM) ||
                   (pif.phase == SM) || (pif.phase == AGGR);

  // count is zero in the valid cycle, so a same-cycle ready measures 0
  assign cur_cnt = phase_start_i ? '0 : cnt_q;

  // record restarts with each new layer
  assign base_longest = (phase_start_i && pif.phase == SPMM) ? '0 : longest_q;

  assign timeout_o = running && !rdy_match && (cur_cnt == LIMIT);
  assign longest_o = longest_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= '0;
      longest_q <= '0;
    end else begin
      if (running) begin
        cnt_q <= (cur_cnt < LIMIT) ? cur_cnt + 1'b1 : cur_cnt;
      end
      if (running && rdy_match) begin
        longest_q <= (cur_cnt > base_longest) ? cur_cnt : base_longest;
      end else begin
        longest_q <= base_longest;
      end
    end
  end

  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= LIMIT)
    else $error("phase count past limit");

  a_abort: assert property (@(posedge clk) disable iff (!rst_n)
    timeout_o |=> pif.phase == IDLE)
    else $error("sequencer ignored timeout");

endmodule

`default_nettype wire

// File: design/debug_probe.sv
`timescale 1ns/1ps
`default_nettype none

module debug_probe #(
  parameter int NUM_PE       = gat_dbg_pkg::NUM_PE,
  parameter int PROBE_PE     = gat_dbg_pkg::DEF_PROBE_PE,
  parameter int PROBE_ADDR_A = gat_dbg_pkg::DEF_PROBE_ADDR_A,
  parameter int PROBE_ADDR_B = gat_dbg_pkg::DEF_PROBE_ADDR_B
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          clear_i,
  phase_if.prb_mp                                       pif,
  input  logic [NUM_PE-1:0][gat_dbg_pkg::SPPE_W-1:0]    sppe_i,
  input  logic [gat_dbg_pkg::WH_ADDR_W-1:0]             wh_addr_i,
  output logic [gat_dbg_pkg::FLAG_W-1:0]                flags_o,
  output logic [gat_dbg_pkg::SPPE_W-1:0]                cap_a_o,
  output logic [gat_dbg_pkg::SPPE_W-1:0]                cap_b_o
);
  import gat_dbg_pkg::*;

  localparam logic [WH_ADDR_W-1:0] ADDR_A = WH_ADDR_W'(PROBE_ADDR_A);
  localparam logic [WH_ADDR_W-1:0] ADDR_B = WH_ADDR_W'(PROBE_ADDR_B);

  logic [FLAG_W-1:0] strobes;
  logic [FLAG_W-1:0] flags_q;
  logic [FLAG_W-1:0] flags_base;
  logic              layer_clear;
  logic              hit_a;
  logic              hit_b;
  logic [SPPE_W-1:0] cap_a_q;
  logic [SPPE_W-1:0] cap_b_q;

  // bit order follows the engine order, valid above ready
  assign strobes = {pif.spmm_vld, pif.spmm_rdy, pif.dmvm_vld, pif.dmvm_rdy,
                    pif.sm_vld,   pif.sm_rdy,   pif.aggr_vld, pif.aggr_rdy};

  // only the spmm phase start marks a new layer
  assign layer_clear = clear_i && (pif.phase == SPMM);
  assign flags_base  = layer_clear ? '0 : flags_q;

  assign hit_a = pif.spmm_rdy && (wh_addr_i == ADDR_A);
  assign hit_b = pif.spmm_rdy && (wh_addr_i == ADDR_B);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      // strobes seen in the clear cycle still set
      flags_q <= flags_base | strobes;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else begin
      if (hit_a) begin
        cap_a_q <= sppe_i[PROBE_PE];
      end
      if (hit_b) begin
        cap_b_q <= sppe_i[PROBE_PE];
      end
    end
  end

  assign flags_o = flags_q;
  assign cap_a_o = cap_a_q;
  assign cap_b_o = cap_b_q;

  a_pe_range: assert property (@(posedge clk) PROBE_PE < NUM_PE)
    else $error("probe pe index out of range");

endmodule

`default_nettype wire

// File: design/gat_dbg_top.sv
`timescale 1ns/1ps
`default_nettype none

module gat_dbg_top #(
  parameter int NUM_PE       = gat_dbg_pkg::NUM_PE,
  parameter int PHASE_LIMIT  = gat_dbg_pkg::DEF_PHASE_LIMIT,
  parameter int PROBE_PE     = gat_dbg_pkg::DEF_PROBE_PE,
  parameter int PROBE_ADDR_A = gat_dbg_pkg::DEF_PROBE_ADDR_A,
  parameter int PROBE_ADDR_B = gat_dbg_pkg::DEF_PROBE_ADDR_B
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       start_i,
  input  logic                                       spmm_rdy_i,
  input  logic                                       dmvm_rdy_i,
  input  logic                                       sm_rdy_i,
  input  logic                                       aggr_rdy_i,
  input  logic [NUM_PE-1:0][gat_dbg_pkg::SPPE_W-1:0] sppe_i,
  input  logic [gat_dbg_pkg::WH_ADDR_W-1:0]          wh_addr_i,
  output logic                                       spmm_vld_o,
  output logic                                       dmvm_vld_o,
  output logic                                       sm_vld_o,
  output logic                                       aggr_vld_o,
  output gat_dbg_pkg::phase_e                        phase_o,
  output logic                                       busy_o,
  output logic                                       done_o,
  output logic                                       error_o,
  output logic [gat_dbg_pkg::CNT_W-1:0]              longest_o,
  output logic [gat_dbg_pkg::FLAG_W-1:0]             flags_o,
  output logic [gat_dbg_pkg::SPPE_W-1:0]             cap_a_o,
  output logic [gat_dbg_pkg::SPPE_W-1:0]             cap_b_o
);

  logic timeout;
  logic phase_start;

  phase_if u_pif ();

  assign u_pif.spmm_rdy = spmm_rdy_i;
  assign u_pif.dmvm_rdy = dmvm_rdy_i;
  assign u_pif.sm_rdy   = sm_rdy_i;
  assign u_pif.aggr_rdy = aggr_rdy_i;

  assign spmm_vld_o = u_pif.spmm_vld;
  assign dmvm_vld_o = u_pif.dmvm_vld;
  assign sm_vld_o   = u_pif.sm_vld;
  assign aggr_vld_o = u_pif.aggr_vld;
  assign phase_o    = u_pif.phase;

  layer_seq u_layer_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .timeout_i     (timeout),
    .phase_start_o (phase_start),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .error_o       (error_o),
    .pif           (u_pif.seq_mp)
  );

  phase_timer #(
    .PHASE_LIMIT (PHASE_LIMIT)
  ) u_phase_timer (
    .clk           (clk),
    .rst_n         (rst_n),
    .phase_start_i (phase_start),
    .pif           (u_pif.tmr_mp),
    .timeout_o     (timeout),
    .longest_o     (longest_o)
  );

  // probe qualifies the clear with the spmm phase itself
  debug_probe #(
    .NUM_PE       (NUM_PE),
    .PROBE_PE     (PROBE_PE),
    .PROBE_ADDR_A (PROBE_ADDR_A),
    .PROBE_ADDR_B (PROBE_ADDR_B)
  ) u_debug_probe (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear_i   (phase_start),
    .pif       (u_pif.prb_mp),
    .sppe_i    (sppe_i),
    .wh_addr_i (wh_addr_i),
    .flags_o   (flags_o),
    .cap_a_o   (cap_a_o),
    .cap_b_o   (cap_b_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_NS      = 2,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // release just after a rising edge, away from the sampling point
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/gat_dbg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module gat_dbg_checker #(
  parameter int NUM_PE       = gat_dbg_pkg::NUM_PE,
  parameter int PHASE_LIMIT  = gat_dbg_pkg::DEF_PHASE_LIMIT,
  parameter int PROBE_PE     = gat_dbg_pkg::DEF_PROBE_PE,
  parameter int PROBE_ADDR_A = gat_dbg_pkg::DEF_PROBE_ADDR_A,
  parameter int PROBE_ADDR_B = gat_dbg_pkg::DEF_PROBE_ADDR_B
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       start_i,
  // bit 0 is spmm, bit 3 is aggr
  input  logic [3:0]                                 rdy_i,
  input  logic [3:0]                                 vld_i,
  input  logic [NUM_PE-1:0][gat_dbg_pkg::SPPE_W-1:0] sppe_i,
  input  logic [gat_dbg_pkg::WH_ADDR_W-1:0]          wh_addr_i,
  input  gat_dbg_pkg::phase_e                        phase_i,
  input  logic                                       busy_i,
  input  logic                                       done_i,
  input  logic                                       error_i,
  input  logic [gat_dbg_pkg::CNT_W-1:0]              longest_i,
  input  logic [gat_dbg_pkg::FLAG_W-1:0]             flags_i,
  input  logic [gat_dbg_pkg::SPPE_W-1:0]             cap_a_i,
  input  logic [gat_dbg_pkg::SPPE_W-1:0]             cap_b_i,
  output int                                         checks_o,
  output int                                         errors_o
);
  import gat_dbg_pkg::*;

  phase_e            m_phase;
  logic              m_entry;
  logic              m_error;
  int                m_age;
  logic [CNT_W-1:0]  m_longest;
  logic [FLAG_W-1:0] m_flags;
  logic [SPPE_W-1:0] m_cap_a;
  logic [SPPE_W-1:0] m_cap_b;
  int                n_checks = 0;
  int                n_errors = 0;

  function automatic int engine_of(input phase_e p);
    case (p)
      SPMM:    return 0;
      DMVM:    return 1;
      SM:      return 2;
      AGGR:    return 3;
      default: return -1;
    endcase
  endfunction

  function automatic phase_e phase_after(input phase_e p);
    case (p)
      SPMM:    return DMVM;
      DMVM:    return SM;
      SM:      return AGGR;
      default: return DONE;
    endcase
  endfunction

  // one hot engine of the phase, gated by the first cycle
  function automatic logic [3:0] ref_valids(input phase_e p, input logic entry);
    if (!entry || engine_of(p) < 0) return 4'b0000;
    return 4'b0001 << engine_of(p);
  endfunction

  function automatic logic [FLAG_W-1:0] ref_strobes(input logic [3:0] v, input logic [3:0] r);
    return {v[0], r[0], v[1], r[1], v[2], r[2], v[3], r[3]};
  endfunction

  function automatic logic [CNT_W-1:0] ref_longest(input logic [CNT_W-1:0] rec,
                                                   input int age, input logic ended);
    if (ended && CNT_W'(age) > rec) return CNT_W'(age);
    return rec;
  endfunction

  always @(posedge clk or negedge rst_n) begin : model
    logic [3:0] v;
    logic       own;
    logic       abort;
    logic       new_layer;
    if (!rst_n) begin
      m_phase   <= IDLE;
      m_entry   <= 1'b0;
      m_error   <= 1'b0;
      m_age     <= 0;
      m_longest <= '0;
      m_flags   <= '0;
      m_cap_a   <= '0;
      m_cap_b   <= '0;
    end else begin
      v         = ref_valids(m_phase, m_entry);
      own       = |(rdy_i & ref_valids(m_phase, 1'b1));
      abort     = engine_of(m_phase) >= 0 && !own && m_age == PHASE_LIMIT;
      new_layer = m_entry && m_phase == SPMM;
      m_flags   <= (new_layer ? '0 : m_flags) | ref_strobes(v, rdy_i);
      m_longest <= ref_longest(new_layer ? '0 : m_longest, m_age, own);
      m_entry   <= 1'b0;
      m_age     <= m_age + 1;
      if (m_phase == IDLE && start_i) begin
        m_phase <= SPMM;
        m_entry <= 1'b1;
        m_error <= 1'b0;
        m_age   <= 0;
      end else if (abort) begin
        m_phase <= IDLE;
        m_error <= 1'b1;
      end else if (own) begin
        m_phase <= phase_after(m_phase);
        m_entry <= (m_phase != AGGR);
        m_age   <= 0;
      end else if (m_phase == DONE) begin
        m_phase <= IDLE;
      end
      if (rdy_i[0] && wh_addr_i == WH_ADDR_W'(PROBE_ADDR_A)) begin
        m_cap_a <= sppe_i[PROBE_PE];
      end
      if (rdy_i[0] && wh_addr_i == WH_ADDR_W'(PROBE_ADDR_B)) begin
        m_cap_b <= sppe_i[PROBE_PE];
      end
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, exp);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    compare("spmm_vld_o", 32'(vld_i[0]), 32'(ref_valids(m_phase, m_entry) >> 0 & 4'd1));
    compare("dmvm_vld_o", 32'(vld_i[1]), 32'(ref_valids(m_phase, m_entry) >> 1 & 4'd1));
    compare("sm_vld_o", 32'(vld_i[2]), 32'(ref_valids(m_phase, m_entry) >> 2 & 4'd1));
    compare("aggr_vld_o", 32'(vld_i[3]), 32'(ref_valids(m_phase, m_entry) >> 3 & 4'd1));
    compare("phase_o", 32'(phase_i), 32'(m_phase));
    compare("busy_o", 32'(busy_i), 32'(engine_of(m_phase) >= 0));
    compare("done_o", 32'(done_i), 32'(m_phase == DONE));
    compare("error_o", 32'(error_i), 32'(m_error));
    compare("longest_o", 32'(longest_i), 32'(m_longest));
    compare("flags_o", 32'(flags_i), 32'(m_flags));
    compare("cap_a_o", 32'(cap_a_i), 32'(m_cap_a));
    compare("cap_b_o", 32'(cap_b_i), 32'(m_cap_b));
  end

  assign checks_o = n_checks;
  assign errors_o = n_errors;

endmodule

`default_nettype wire

// File: dv/gat_dbg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gat_dbg_tb;
  import gat_dbg_pkg::*;

  localparam int PHASE_LIMIT = 40;
  localparam int NUM_LAYERS  = 20;
  localparam int HANG_DELAY  = 60;
  localparam int MAX_CYCLES  = NUM_LAYERS * 4 * (HANG_DELAY + 1) + 500;

  logic                          clk;
  logic                          rst_n;
  logic                          start;
  logic [3:0]                    rdy;
  logic [3:0]                    vld;
  logic [NUM_PE-1:0][SPPE_W-1:0] sppe;
  logic [WH_ADDR_W-1:0]          wh_addr;
  phase_e                        phase;
  logic                          busy;
  logic                          done;
  logic                          layer_err;
  logic [CNT_W-1:0]              longest;
  logic [FLAG_W-1:0]             flags;
  logic [SPPE_W-1:0]             cap_a;
  logic [SPPE_W-1:0]             cap_b;
  logic [31:0]                   lfsr;
  int                            checks;
  int                            errors;
  int                            stim_errs;
  int                            cycles;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_dbg_top #(
    .PHASE_LIMIT (PHASE_LIMIT)
  ) u_gat_dbg_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start),
    .spmm_rdy_i (rdy[0]),
    .dmvm_rdy_i (rdy[1]),
    .sm_rdy_i   (rdy[2]),
    .aggr_rdy_i (rdy[3]),
    .sppe_i     (sppe),
    .wh_addr_i  (wh_addr),
    .spmm_vld_o (vld[0]),
    .dmvm_vld_o (vld[1]),
    .sm_vld_o   (vld[2]),
    .aggr_vld_o (vld[3]),
    .phase_o    (phase),
    .busy_o     (busy),
    .done_o     (done),
    .error_o    (layer_err),
    .longest_o  (longest),
    .flags_o    (flags),
    .cap_a_o    (cap_a),
    .cap_b_o    (cap_b)
  );

  gat_dbg_checker #(
    .PHASE_LIMIT (PHASE_LIMIT)
  ) u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (start),
    .rdy_i     (rdy),
    .vld_i     (vld),
    .sppe_i    (sppe),
    .wh_addr_i (wh_addr),
    .phase_i   (phase),
    .busy_i    (busy),
    .done_i    (done),
    .error_i   (layer_err),
    .longest_i (longest),
    .flags_i   (flags),
    .cap_a_i   (cap_a),
    .cap_b_i   (cap_b),
    .checks_o  (checks),
    .errors_o  (errors)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // half the cycles sit on one of the probed addresses
  task automatic new_data();
    logic [31:0] r;
    rand_bits(2, r);
    case (r[1:0])
      2'd0:    wh_addr = WH_ADDR_W'(DEF_PROBE_ADDR_A);
      2'd1:    wh_addr = WH_ADDR_W'(DEF_PROBE_ADDR_B);
      default: begin
        rand_bits(WH_ADDR_W, r);
        wh_addr = r[WH_ADDR_W-1:0];
      end
    endcase
    for (int i = 0; i < NUM_PE; i++) begin
      rand_bits(SPPE_W, r);
      sppe[i] = r[SPPE_W-1:0];
    end
  endtask

  // strobes last one cycle, dropped here
  task automatic step();
    @(posedge clk);
    #1;
    start = 1'b0;
    rdy = '0;
    new_data();
  endtask

  // occasional ready from an engine that does not own the phase
  task automatic maybe_stray(input logic [1:0] eng);
    logic [31:0] r;
    logic [1:0]  other;
    rand_bits(4, r);
    if (r[3:0] == 4'd0) begin
      rand_bits(2, r);
      other = eng + ((r[1:0] == 2'd3) ? 2'd1 : r[1:0] + 2'd1);
      rdy[other] = 1'b1;
    end
  endtask

  task automatic run_phase(input logic [1:0] eng, input int delay, output logic seen);
    seen = vld[eng];
    for (int i = 0; i < 4 && !seen; i++) begin
      step();
      seen = vld[eng];
    end
    if (!seen) begin
      stim_errs++;
      $display("engine %0d never received its valid", eng);
    end else begin
      for (int i = 0; i < delay; i++) begin
        maybe_stray(eng);
        step();
      end
      rdy[eng] = 1'b1;
      step();
    end
  endtask

  task automatic run_layer(input int hang_eng);
    logic [31:0] r;
    logic        go;
    int          delay;
    int          waited;
    start = 1'b1;
    step();
    go = 1'b1;
    for (int p = 0; p < 4 && go; p++) begin
      rand_bits(4, r);
      delay = (p == hang_eng) ? HANG_DELAY : int'(r[3:0]);
      run_phase(2'(p), delay, go);
      // the late ready of a hung engine lands in idle
      if (p == hang_eng) go = 1'b0;
    end
    waited = 0;
    while ((busy || done) && waited < 8) begin
      step();
      waited++;
    end
    if (busy || done) begin
      stim_errs++;
      $display("layer did not return to idle");
    end
  endtask

  initial begin
    logic [31:0] r;
    start = 1'b0;
    rdy = '0;
    sppe = '0;
    wh_addr = '0;
    lfsr = 32'h5e9192e0;
    stim_errs = 0;
    @(posedge rst_n);
    repeat (3) step();
    for (int l = 0; l < NUM_LAYERS; l++) begin
      // every fifth layer hangs one engine, each engine once
      run_layer((l % 5 == 4) ? (l / 5) % 4 : -1);
      rand_bits(2, r);
      for (int i = 0; i < int'(r[1:0]); i++) begin
        maybe_stray(2'd0);
        step();
      end
    end
    repeat (2) step();
    if (checks == 0) begin
      stim_errs++;
      $display("checker compared nothing");
    end
    $display("checks %0d, mismatches %0d, stimulus errors %0d", checks, errors, stim_errs);
    if (errors == 0 && stim_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", MAX_CYCLES);
    $display("checks %0d, mismatches %0d, stimulus errors %0d", checks, errors, stim_errs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/gat_dbg_pkg.sv
design/phase_if.sv
design/layer_seq.sv
design/phase_timer.sv
design/debug_probe.sv
design/gat_dbg_top.sv
dv/tb_clk_gen.sv
dv/gat_dbg_checker.sv
dv/gat_dbg_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := gat_dbg_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := SIMULATION PASSED
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
